//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address after reset
// kseg1 boot rom entry
`define FETCH_RESET_PC 32'hbfc0_0000

// sequential advance for one aligned pair
// two 32-bit instructions per fetch
`define FETCH_STEP 32'd8

// instruction bus data width
// one pair per beat with slot 0 in the low half
`define FETCH_BUS_WIDTH 64

// byte offset bits below the pair boundary
`define FETCH_PAIR_MASK 32'h0000_0007

`endif

//--- fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // pcs, bus addresses and single instructions
    typedef logic [31:0] word_t;

    // one bus beat
    // first instruction in bits 31:0, second in bits 63:32
    typedef logic [`FETCH_BUS_WIDTH-1:0] bus_data_t;

    // how a fetch pc is treated along the front end
    // kind_normal carries a full pair
    // kind_single has pc bit 2 set so only the high half is used
    // kind_misaligned raises a fetch exception and skips the bus
    typedef enum logic [1:0] {
        kind_normal     = 2'd0,
        kind_single     = 2'd1,
        kind_misaligned = 2'd2
    } fetch_kind_t;

endpackage

//--- fetch_req_if.sv
`timescale 1ns/1ps

// pc requests from the pc generator to the bus master
interface fetch_req_if;
    import fetch_pkg::*;

    // request handshake
    logic        valid;
    logic        ready;
    // fetch address and its class
    word_t       pc;
    fetch_kind_t kind;
    // redirect in this cycle
    // everything older is stale
    logic        kill;

    modport source (
        output valid, pc, kind, kill,
        input  ready
    );

    modport sink (
        input  valid, pc, kind, kill,
        output ready
    );

endinterface

//--- fetch_pair_if.sv
`timescale 1ns/1ps

// fetched pairs from the bus master to the output buffer
interface fetch_pair_if;
    import fetch_pkg::*;

    // pair handshake
    logic        valid;
    logic        ready;
    // pc of the request that produced this pair
    word_t       pc;
    bus_data_t   data;
    fetch_kind_t kind;
    // forwarded request kill
    logic        kill;

    modport source (
        output valid, pc, data, kind, kill,
        input  ready
    );

    modport sink (
        input  valid, pc, data, kind, kill,
        output ready
    );

endinterface

//--- fetch_pc_gen.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_pc_gen (
    input  logic            clk,
    input  logic            reset,
    input  logic            exc_redirect,
    input  fetch_pkg::word_t exc_pc,
    input  logic            br_redirect,
    input  fetch_pkg::word_t br_pc,
    fetch_req_if.source     req
);
    import fetch_pkg::*;

    // fetch pc register
    word_t       pc_q;
    // set after a misaligned request went out
    logic        halted;
    // redirect of either source in this cycle
    logic        redirect;
    // winning target
    word_t       redirect_pc;
    // class of the current pc
    fetch_kind_t pc_kind;
    // request taken by the bus master
    logic        accepted;
    // next pc on the sequential path
    word_t       seq_pc;

    // exception or return redirect beats the branch
    assign redirect    = exc_redirect | br_redirect;
    assign redirect_pc = exc_redirect ? exc_pc : br_pc;

    // low two bits set means no valid instruction address
    always_comb begin
        if (pc_q[1:0] != 2'b00) begin
            pc_kind = kind_misaligned;
        end else if (pc_q[2]) begin
            pc_kind = kind_single;
        end else begin
            pc_kind = kind_normal;
        end
    end

    // single pc realigns to the next pair boundary
    always_comb begin
        if (pc_kind == kind_single) begin
            seq_pc = (pc_q & ~`FETCH_PAIR_MASK) + `FETCH_STEP;
        end else begin
            seq_pc = pc_q + `FETCH_STEP;
        end
    end

    // present the pc every cycle unless halted
    assign req.valid = ~halted;
    assign req.pc    = pc_q;
    assign req.kind  = pc_kind;
    assign req.kill  = redirect;

    assign accepted = req.valid & req.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q   <= `FETCH_RESET_PC;
            halted <= 1'b0;
        end else if (redirect) begin
            // redirect overwrites the pc even with a request waiting
            pc_q   <= redirect_pc;
            halted <= 1'b0;
        end else if (accepted) begin
            if (pc_kind == kind_misaligned) begin
                // wait here for the next redirect
                halted <= 1'b1;
            end else begin
                pc_q <= seq_pc;
            end
        end
    end

    // bus master only sees word aligned pcs for real fetches
    assert property (@(posedge clk) disable iff (reset)
        req.valid && req.ready && req.kind != kind_misaligned |-> req.pc[1:0] == 2'b00);

endmodule

//--- ibus_master.sv
`timescale 1ns/1ps

module ibus_master (
    input  logic                 clk,
    input  logic                 reset,
    fetch_req_if.sink            req,
    fetch_pair_if.source         pair,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output fetch_pkg::word_t     wb_adr,
    input  fetch_pkg::bus_data_t wb_dat,
    input  logic                 wb_ack
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_bus  = 2'd1,
        st_hold = 2'd2
    } state_t;

    state_t      state;
    // response of the running cycle is stale
    logic        discard;
    logic        accept;
    // captured request and the one-pair hold
    word_t       pc_q;
    fetch_kind_t kind_q;
    bus_data_t   data_q;

    // only a fresh request in idle
    assign req.ready = (state == st_idle) & ~req.kill;
    assign accept    = req.valid & req.ready;

    // classic cycle lasts the whole bus state
    assign wb_cyc = (state == st_bus);
    assign wb_stb = (state == st_bus);
    // pair aligned address
    assign wb_adr = {pc_q[31:3], 3'b000};

    // the hold offers its pair downstream
    assign pair.valid = (state == st_hold);
    assign pair.pc    = pc_q;
    assign pair.data  = data_q;
    assign pair.kind  = kind_q;
    assign pair.kill  = req.kill;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            discard <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    discard <= 1'b0;
                    if (accept) begin
                        // misaligned pc goes straight to the hold
                        state <= (req.kind == kind_misaligned) ? st_hold : st_bus;
                    end
                end
                st_bus: begin
                    if (wb_ack) begin
                        // stale data is dropped after the ack
                        state   <= (discard | req.kill) ? st_idle : st_hold;
                        discard <= 1'b0;
                    end else if (req.kill) begin
                        discard <= 1'b1;
                    end
                end
                st_hold: begin
                    if (req.kill | pair.ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request and data capture
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q   <= req.pc;
            kind_q <= req.kind;
            if (req.kind == kind_misaligned) begin
                data_q <= '0;
            end
        end
        if (state == st_bus && wb_ack) begin
            data_q <= wb_dat;
        end
    end

    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc);

    // address holds until the slave acknowledges
    assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

//--- fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer (
    input  logic             clk,
    input  logic             reset,
    fetch_pair_if.sink       pair,
    output logic             out_valid,
    input  logic             out_ready,
    output fetch_pkg::word_t out_pc,
    output fetch_pkg::word_t out_instr0,
    output fetch_pkg::word_t out_instr1,
    output logic             out_exc
);
    import fetch_pkg::*;

    // output register
    logic        valid_q;
    word_t       pc_q;
    bus_data_t   data_q;
    fetch_kind_t kind_q;

    // room when empty or the current pair leaves this cycle
    assign pair.ready = ~valid_q | out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (pair.kill) begin
            // redirect empties the slot
            valid_q <= 1'b0;
        end else if (pair.ready) begin
            valid_q <= pair.valid;
        end
    end

    // payload follows the load condition
    always_ff @(posedge clk) begin
        if (!pair.kill && pair.ready && pair.valid) begin
            pc_q   <= pair.pc;
            data_q <= pair.data;
            kind_q <= pair.kind;
        end
    end

    // split the pair into the two issue slots
    always_comb begin
        case (kind_q)
            kind_normal: begin
                out_instr0 = data_q[31:0];
                out_instr1 = data_q[63:32];
            end
            kind_single: begin
                // entry at pc bit 2 uses the upper word only
                out_instr0 = data_q[63:32];
                out_instr1 = '0;
            end
            default: begin
                // fetch exception carries no instructions
                out_instr0 = '0;
                out_instr1 = '0;
            end
        endcase
    end

    assign out_valid = valid_q;
    assign out_pc    = pc_q;
    assign out_exc   = valid_q & (kind_q == kind_misaligned);

    // stalled output holds unless a redirect flushes it
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !pair.kill |=>
            out_valid && $stable(out_pc) && $stable(out_instr0) &&
            $stable(out_instr1) && $stable(out_exc));

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset,
    // wishbone classic read master
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output fetch_pkg::word_t     wb_adr,
    input  fetch_pkg::bus_data_t wb_dat,
    input  logic                 wb_ack,
    // redirects from the back end
    input  logic                 exc_redirect,
    input  fetch_pkg::word_t     exc_pc,
    input  logic                 br_redirect,
    input  fetch_pkg::word_t     br_pc,
    // instruction pair toward decode
    output logic                 out_valid,
    input  logic                 out_ready,
    output fetch_pkg::word_t     out_pc,
    output fetch_pkg::word_t     out_instr0,
    output fetch_pkg::word_t     out_instr1,
    output logic                 out_exc
);

    fetch_req_if  req_bus ();
    fetch_pair_if pair_bus ();

    // pc register and redirect selection
    fetch_pc_gen pc_gen0 (
        .clk,
        .reset,
        .exc_redirect,
        .exc_pc,
        .br_redirect,
        .br_pc,
        .req (req_bus.source)
    );

    // bus cycles and the one-pair hold
    ibus_master ibus0 (
        .clk,
        .reset,
        .req  (req_bus.sink),
        .pair (pair_bus.source),
        .wb_cyc,
        .wb_stb,
        .wb_adr,
        .wb_dat,
        .wb_ack
    );

    // output slot register
    fetch_buffer buffer0 (
        .clk,
        .reset,
        .pair (pair_bus.sink),
        .out_valid,
        .out_ready,
        .out_pc,
        .out_instr0,
        .out_instr1,
        .out_exc
    );

endmodule

//--- tb_ibus_mem.sv
`timescale 1ns/1ps

// wishbone classic read slave for the fetch testbench
// each 32-bit word reads back as its byte address xor a pattern
module tb_ibus_mem #(
    parameter logic [31:0] pattern = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic [31:0] adr,
    output logic [63:0] dat,
    output logic        ack,
    output int          reads
);

    // cycles left before the running strobe is answered
    logic [1:0] wait_left;

    // zero delay answers in the first strobe cycle
    assign ack = cyc & stb & (wait_left == 2'd0);

    // low word at adr, high word at adr + 4
    always_comb begin
        if (ack) begin
            dat = {(adr + 32'd4) ^ pattern, adr ^ pattern};
        end else begin
            dat = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_left <= 2'($urandom_range(3, 0));
            reads     <= 0;
        end else if (ack) begin
            // fresh delay for the next strobe
            wait_left <= 2'($urandom_range(3, 0));
            reads     <= reads + 1;
        end else if (cyc && stb) begin
            wait_left <= wait_left - 2'd1;
        end
    end

endmodule

//--- tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam logic [31:0] reset_pc    = 32'hbfc0_0000;
    localparam logic [31:0] mem_pattern = 32'h5a3c_96e1;
    // six phases of about 400 cycles plus margin
    localparam int          max_cycles  = 3000;

    logic        clk;
    logic        reset;
    logic        wb_cyc, wb_stb, wb_ack;
    logic [31:0] wb_adr;
    logic [63:0] wb_dat;
    logic        exc_redirect, br_redirect;
    logic [31:0] exc_pc, br_pc;
    logic        out_valid, out_ready, out_exc;
    logic [31:0] out_pc, out_instr0, out_instr1;

    string       test_name;
    logic        random_ready;
    logic        redirect;
    // reference model of the fetch stream
    logic [31:0] exp_pc;
    logic        exp_halted;
    logic [31:0] prev_pc;
    int          pair_count, exc_pairs, single_pairs, bus_reads;
    int          mismatch_count, other_count, cycles;

    fetch_top dut0 (.*);

    tb_ibus_mem #(.pattern(mem_pattern)) mem0 (
        .clk, .reset, .cyc(wb_cyc), .stb(wb_stb), .adr(wb_adr),
        .dat(wb_dat), .ack(wb_ack), .reads(bus_reads)
    );

    assign redirect = exc_redirect | br_redirect;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory word at a byte address
    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return addr ^ mem_pattern;
    endfunction

    // slot 0 holds the word at pc for both normal and single fetches
    function automatic logic [31:0] slot0_word(input logic [31:0] pc);
        return (pc[1:0] != 2'b00) ? 32'h0 : pattern_word(pc);
    endfunction

    function automatic logic [31:0] slot1_word(input logic [31:0] pc);
        return (pc[1:0] != 2'b00 || pc[2]) ? 32'h0 : pattern_word(pc + 32'd4);
    endfunction

    // expected pc stream, updated on every accepted pair and redirect
    always @(posedge clk) begin
        prev_pc <= out_pc;
        if (reset) begin
            exp_pc       <= reset_pc;
            exp_halted   <= 1'b0;
            pair_count   <= 0;
            exc_pairs    <= 0;
            single_pairs <= 0;
        end else begin
            if (out_valid && out_ready) begin
                pair_count <= pair_count + 1;
                if (exp_pc[1:0] != 2'b00) begin
                    exc_pairs  <= exc_pairs + 1;
                    exp_halted <= 1'b1;
                end else if (exp_pc[2]) begin
                    // a lone upper word is followed by the word after it
                    single_pairs <= single_pairs + 1;
                    exp_pc       <= exp_pc + 32'd4;
                end else begin
                    exp_pc <= exp_pc + 32'd8;
                end
            end
            // exception target wins over the branch
            if (redirect) begin
                exp_pc     <= exc_redirect ? exc_pc : br_pc;
                exp_halted <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready |-> out_pc == exp_pc)
    else begin
        mismatch_count++;
        $display("MISMATCH %s out_pc expected %h actual %h",
                 test_name, $sampled(exp_pc), $sampled(out_pc));
    end

    // exc flag and both slots as one word
    assert property (@(posedge clk) disable iff (reset)
        out_valid && out_ready |-> out_exc == (exp_pc[1:0] != 2'b00) &&
            out_instr0 == slot0_word(exp_pc) && out_instr1 == slot1_word(exp_pc))
    else begin
        mismatch_count++;
        $display("MISMATCH %s exc,instr0,instr1 expected %h actual %h", test_name,
                 {$sampled(exp_pc[1:0] != 2'b00), slot0_word($sampled(exp_pc)),
                  slot1_word($sampled(exp_pc))},
                 {$sampled(out_exc), $sampled(out_instr0), $sampled(out_instr1)});
    end

    // stalled pair holds unless flushed
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !redirect |=> out_valid && out_pc == prev_pc &&
            $stable(out_instr0) && $stable(out_instr1) && $stable(out_exc))
    else begin
        mismatch_count++;
        $display("MISMATCH %s held out_pc expected %h actual %h",
                 test_name, $sampled(prev_pc), $sampled(out_pc));
    end

    assert property (@(posedge clk) disable iff (reset) redirect |=> !out_valid)
    else begin
        other_count++;
        $display("%s: out_valid was high in the cycle after a redirect", test_name);
    end

    // misaligned fetch halts everything until a redirect
    assert property (@(posedge clk) disable iff (reset) exp_halted |-> !wb_stb && !out_valid)
    else begin
        other_count++;
        $display("%s: bus or output active after a misaligned fetch", test_name);
    end

    assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_adr[2:0] == 3'b000)
    else begin
        mismatch_count++;
        $display("MISMATCH %s wb_adr low bits expected 0 actual %0d",
                 test_name, $sampled(wb_adr[2:0]));
    end

    // cyc and stb rise and fall together in a classic read
    assert property (@(posedge clk) disable iff (reset) wb_cyc == wb_stb)
    else begin
        mismatch_count++;
        $display("MISMATCH %s wb_cyc expected %b actual %b",
                 test_name, $sampled(wb_stb), $sampled(wb_cyc));
    end

    // bus and output idle out of reset
    assert property (@(posedge clk) $fell(reset) |-> !wb_cyc && !wb_stb && !out_valid)
    else begin
        other_count++;
        $display("%s: bus or output active right after reset", test_name);
    end

    // back-pressure source, always ready outside the random phases
    initial begin
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            out_ready <= random_ready ? ($urandom_range(1, 0) == 1) : 1'b1;
        end
    end

    task automatic print_counts(input int gaps);
        $display("result: %0d mismatches, %0d other errors, %0d pairs, %0d bus reads",
                 mismatch_count, other_count + gaps, pair_count, bus_reads);
    endtask

    // counts only pairs accepted after the next edge
    task automatic wait_pairs(input int n);
        int target;
        @(posedge clk);
        target = pair_count + n;
        while (pair_count < target) begin
            @(posedge clk);
        end
    endtask

    // one-cycle redirect pulse
    task automatic redirect_to(input logic exc, input logic [31:0] epc,
                               input logic br, input logic [31:0] bpc);
        @(posedge clk);
        exc_redirect <= exc;
        exc_pc       <= epc;
        br_redirect  <= br;
        br_pc        <= bpc;
        @(posedge clk);
        exc_redirect <= 1'b0;
        br_redirect  <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("run stopped by timeout after %0d cycles in %s", cycles, test_name);
            print_counts(0);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int gaps;
        void'($urandom(32'h7ec5_4fae));
        gaps = 0;
        reset        <= 1'b1;
        exc_redirect <= 1'b0;
        exc_pc       <= '0;
        br_redirect  <= 1'b0;
        br_pc        <= '0;
        random_ready <= 1'b0;
        test_name = "reset_sequence";
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_pairs(20);

        test_name = "backpressure";
        random_ready <= 1'b1;
        wait_pairs(30);

        test_name = "branch_redirect";
        for (int i = 0; i < 4; i++) begin
            random_ready <= (i % 2 == 1);
            redirect_to(1'b0, '0, 1'b1, 32'h8000_0000 | ($urandom & 32'h000f_fff8));
            wait_pairs(8);
        end

        test_name = "exc_priority";
        for (int i = 0; i < 3; i++) begin
            redirect_to(1'b1, 32'hbfc0_4000 + i * 32'h100, 1'b1, 32'h8000_1000);
            wait_pairs(8);
        end

        // entry at pc bit 2, from each redirect source
        test_name = "single_slot";
        redirect_to(1'b0, '0, 1'b1, 32'hbfc0_3004);
        wait_pairs(6);
        random_ready <= 1'b1;
        redirect_to(1'b1, 32'h8000_200c, 1'b0, '0);
        wait_pairs(6);

        test_name = "misaligned_fetch";
        random_ready <= 1'b0;
        redirect_to(1'b0, '0, 1'b1, 32'hbfc0_5002);
        wait_pairs(1);
        repeat (40) @(posedge clk);
        redirect_to(1'b1, 32'hbfc0_6001, 1'b0, '0);
        wait_pairs(1);
        repeat (40) @(posedge clk);
        redirect_to(1'b0, '0, 1'b1, 32'hbfc0_0100);
        wait_pairs(8);

        if (exc_pairs == 0 || single_pairs == 0) begin
            $display("no fetch exception or no single slot pair reached the output");
            gaps++;
        end
        print_counts(gaps);
        if (mismatch_count + other_count + gaps == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
fetch_pkg.sv
fetch_req_if.sv
fetch_pair_if.sv
fetch_pc_gen.sv
ibus_master.sv
fetch_buffer.sv
fetch_top.sv
tb_ibus_mem.sv
tb_fetch_top.sv

//--- Makefile
# verilator flow for the fetch front end

.PHONY: all run lint clean

all: run

obj_dir/sim: sim.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -f sim.f --top-module tb_fetch_top -o sim

# the log decides pass or fail
run: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -qx "test passed" sim.log

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_fetch_top
	verilator --lint-only --assert +incdir+. fetch_pkg.sv fetch_req_if.sv \
		fetch_pair_if.sv fetch_pc_gen.sv ibus_master.sv fetch_buffer.sv \
		fetch_top.sv --top-module fetch_top

clean:
	rm -rf obj_dir sim.log
